// ==== sources.f ====
huff_pkg.sv
word_sram.sv
record_sequencer.sv
hist_counter.sv
codebook_loader.sv
symbol_lookup.sv
huff_mem_top.sv
tb_huff_mem.sv

// ==== Bender.yml ====
package:
  name: huff_mem

sources:
  - huff_pkg.sv
  - word_sram.sv
  - record_sequencer.sv
  - hist_counter.sv
  - codebook_loader.sv
  - symbol_lookup.sv
  - huff_mem_top.sv
  - target: simulation
    files:
      - tb_huff_mem.sv

// ==== tb_huff_mem.sv ====
module tb_huff_mem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 4000;
    localparam int SEL_BYTE = 0;
    localparam int SEL_CB = 1;
    localparam int SEL_Q = 2;
    localparam int SEL_DONE = 3;

    logic clk = 1'b0;
    logic rst;
    huff_pkg::mode_e mode;
    logic clear_start;
    logic byte_valid;
    logic [7:0] byte_in;
    logic byte_ready;
    logic cb_valid;
    logic [7:0] cb_sym;
    huff_pkg::cb_entry_t cb_entry;
    logic cb_ready;
    logic q_valid;
    logic [7:0] q_sym;
    logic q_ready;
    logic rsp_valid;
    huff_pkg::query_rsp_t rsp;
    logic clear_done;

    // reference model state
    logic [31:0] hist_m [256];
    huff_pkg::cb_entry_t cb_m [256];
    bit cb_loaded [256];
    logic [7:0] loaded_q [$];
    huff_pkg::query_rsp_t exp_q [$];

    integer seed;
    int checks;
    int errors;
    int tests;
    int test_checks;
    int test_errors;
    string cur_test;

    huff_mem_top huff_mem_top_i (
        .clk          (clk),
        .rst          (rst),
        .mode_i       (mode),
        .clear_start_i(clear_start),
        .byte_valid_i (byte_valid),
        .byte_i       (byte_in),
        .byte_ready_o (byte_ready),
        .cb_valid_i   (cb_valid),
        .cb_sym_i     (cb_sym),
        .cb_entry_i   (cb_entry),
        .cb_ready_o   (cb_ready),
        .q_valid_i    (q_valid),
        .q_sym_i      (q_sym),
        .q_ready_o    (q_ready),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp),
        .clear_done_o (clear_done)
    );

    always #5 clk = ~clk;

    // expected response built from the model arrays
    function automatic huff_pkg::query_rsp_t expected_rsp(input logic [7:0] sym,
                                                          input huff_pkg::rsp_kind_e kind);
        huff_pkg::query_rsp_t r;
        r.sym = sym;
        r.kind = kind;
        if (kind == huff_pkg::RSP_CB) begin
            r.data = cb_m[sym];
        end else begin
            r.data = {96'd0, hist_m[sym]};
        end
        return r;
    endfunction

    function automatic logic ready_sig(input int sel);
        case (sel)
            SEL_BYTE: return byte_ready;
            SEL_CB: return cb_ready;
            SEL_Q: return q_ready;
            default: return clear_done;
        endcase
    endfunction

    task automatic check_flag(input string label, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s (%s): expected %b, actual %b", cur_test, label, exp, act);
        end
    endtask

    task automatic check_count(input string label, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s (%s): expected %0d, actual %0d", cur_test, label, exp, act);
        end
    endtask

    task automatic check_entry(input string label, input huff_pkg::cb_entry_t exp,
                               input huff_pkg::cb_entry_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s (%s): expected %h, actual %h", cur_test, label, exp, act);
        end
    endtask

    task automatic check_tag(input string label, input huff_pkg::query_rsp_t exp,
                             input huff_pkg::query_rsp_t act);
        checks++;
        if (exp.sym !== act.sym || exp.kind !== act.kind) begin
            errors++;
            $display("ERR %s (%s): expected sym %0d kind %s, actual sym %0d kind %s",
                     cur_test, label, exp.sym, exp.kind.name(), act.sym, act.kind.name());
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        while (!ready_sig(sel)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run($sformatf("timeout waiting for %s", what));
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for query responses");
        end
    endtask

    // settle cycle after each mode change
    task automatic set_mode(input huff_pkg::mode_e m);
        @(negedge clk);
        mode = m;
        @(negedge clk);
    endtask

    task automatic run_clear();
        set_mode(huff_pkg::MODE_CLEAR);
        clear_start = 1'b1;
        @(negedge clk);
        clear_start = 1'b0;
        wait_for(SEL_DONE, "clear_done_o");
        for (int i = 0; i < 256; i++) begin
            hist_m[i] = '0;
        end
        set_mode(huff_pkg::MODE_IDLE);
    endtask

    task automatic send_byte(input logic [7:0] b);
        byte_in = b;
        byte_valid = 1'b1;
        wait_for(SEL_BYTE, "byte_ready_o");
        @(negedge clk);
        byte_valid = 1'b0;
        hist_m[b] = hist_m[b] + 32'd1;
    endtask

    task automatic send_entry(input logic [7:0] sym, input huff_pkg::cb_entry_t e);
        cb_sym = sym;
        cb_entry = e;
        cb_valid = 1'b1;
        wait_for(SEL_CB, "cb_ready_o");
        @(negedge clk);
        cb_valid = 1'b0;
        cb_m[sym] = e;
        if (!cb_loaded[sym]) begin
            cb_loaded[sym] = 1'b1;
            loaded_q.push_back(sym);
        end
    endtask

    task automatic send_query(input logic [7:0] sym);
        huff_pkg::rsp_kind_e kind;
        kind = (mode == huff_pkg::MODE_QUERY_CB) ? huff_pkg::RSP_CB : huff_pkg::RSP_HIST;
        exp_q.push_back(expected_rsp(sym, kind));
        q_sym = sym;
        q_valid = 1'b1;
        wait_for(SEL_Q, "q_ready_o");
        @(negedge clk);
        q_valid = 1'b0;
    endtask

    task automatic query_loaded();
        set_mode(huff_pkg::MODE_QUERY_CB);
        foreach (loaded_q[i]) begin
            send_query(loaded_q[i]);
        end
        wait_drain();
        set_mode(huff_pkg::MODE_IDLE);
    endtask

    task automatic query_all_hist();
        set_mode(huff_pkg::MODE_QUERY_HIST);
        for (int i = 0; i < 256; i++) begin
            send_query(8'(i));
        end
        wait_drain();
        set_mode(huff_pkg::MODE_IDLE);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %0d checks, %0d errors", cur_test, checks - test_checks,
                 errors - test_errors);
    endtask

    // responses are matched in request order
    always @(negedge clk) begin : compare_rsp
        huff_pkg::query_rsp_t exp;
        string label;
        if (rst === 1'b0 && rsp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response for symbol %0d arrived with no query pending", rsp.sym);
            end else begin
                exp = exp_q.pop_front();
                label = $sformatf("sym %0d", exp.sym);
                check_tag(label, exp, rsp);
                if (exp.kind == huff_pkg::RSP_CB) begin
                    check_entry(label, huff_pkg::cb_entry_t'(exp.data),
                                huff_pkg::cb_entry_t'(rsp.data));
                end else begin
                    check_count(label, exp.data[31:0], rsp.data[31:0]);
                    // words above the count stay zero
                    for (int w = 1; w < 4; w++) begin
                        check_count($sformatf("%s word %0d", label, w),
                                    exp.data[w*32 +: 32], rsp.data[w*32 +: 32]);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        huff_pkg::cb_entry_t e;
        seed = 32'h5f40eb69;
        rst = 1'b1;
        mode = huff_pkg::MODE_IDLE;
        clear_start = 1'b0;
        byte_valid = 1'b0;
        byte_in = '0;
        cb_valid = 1'b0;
        cb_sym = '0;
        cb_entry = '0;
        q_valid = 1'b0;
        q_sym = '0;
        checks = 0;
        errors = 0;
        tests = 0;
        for (int i = 0; i < 256; i++) begin
            hist_m[i] = '0;
            cb_m[i] = '0;
            cb_loaded[i] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        begin_test("reset_clear");
        check_flag("byte_ready_o", 1'b0, byte_ready);
        check_flag("cb_ready_o", 1'b0, cb_ready);
        check_flag("q_ready_o", 1'b0, q_ready);
        check_flag("rsp_valid_o", 1'b0, rsp_valid);
        check_flag("clear_done_o", 1'b0, clear_done);
        run_clear();
        set_mode(huff_pkg::MODE_QUERY_HIST);
        for (int i = 0; i < 16; i++) begin
            send_query(8'($random(seed)));
        end
        wait_drain();
        set_mode(huff_pkg::MODE_IDLE);
        end_test();

        begin_test("count");
        set_mode(huff_pkg::MODE_COUNT);
        for (int i = 0; i < 300; i++) begin
            send_byte(8'($random(seed)));
        end
        wait_for(SEL_BYTE, "last count to finish");
        set_mode(huff_pkg::MODE_IDLE);
        query_all_hist();
        end_test();

        // narrow symbol range so some symbols get loaded twice
        begin_test("load");
        set_mode(huff_pkg::MODE_LOAD);
        for (int i = 0; i < 32; i++) begin
            e = {$random(seed), $random(seed), $random(seed), $random(seed)};
            send_entry(8'($random(seed)) & 8'h3f, e);
        end
        wait_for(SEL_CB, "last load to finish");
        set_mode(huff_pkg::MODE_IDLE);
        query_loaded();
        end_test();

        begin_test("order");
        set_mode(huff_pkg::MODE_QUERY_HIST);
        for (int i = 0; i < 8; i++) begin
            send_query(8'($random(seed)));
        end
        wait_drain();
        set_mode(huff_pkg::MODE_QUERY_CB);
        for (int i = 0; i < 8; i++) begin
            send_query(loaded_q[{$random(seed)} % loaded_q.size()]);
        end
        wait_drain();
        set_mode(huff_pkg::MODE_IDLE);
        end_test();

        begin_test("reclear");
        run_clear();
        query_all_hist();
        query_loaded();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== huff_mem_top.sv ====
module huff_mem_top (
    input  logic clk,
    input  logic rst,
    input  huff_pkg::mode_e mode_i,
    input  logic clear_start_i,
    input  logic byte_valid_i,
    input  logic [7:0] byte_i,
    output logic byte_ready_o,
    input  logic cb_valid_i,
    input  logic [7:0] cb_sym_i,
    input  huff_pkg::cb_entry_t cb_entry_i,
    output logic cb_ready_o,
    input  logic q_valid_i,
    input  logic [7:0] q_sym_i,
    output logic q_ready_o,
    output logic rsp_valid_o,
    output huff_pkg::query_rsp_t rsp_o,
    output logic clear_done_o
);

    logic gnt_hist;
    logic gnt_load;
    logic gnt_query;
    logic hist_valid;
    logic load_valid;
    logic query_valid;
    huff_pkg::rec_req_t hist_rec;
    huff_pkg::rec_req_t load_rec;
    huff_pkg::rec_req_t query_rec;
    logic seq_valid;
    huff_pkg::rec_req_t seq_rec;
    logic seq_ready;
    logic seq_done;
    logic [huff_pkg::REC_W-1:0] seq_rdata;
    huff_pkg::mem_req_t mem_req;
    logic mem_go;
    logic mem_busy;
    logic [huff_pkg::WORD_W-1:0] mem_rdata;

    // grant follows mode, which only changes while idle
    assign gnt_hist = (mode_i == huff_pkg::MODE_CLEAR) || (mode_i == huff_pkg::MODE_COUNT);
    assign gnt_load = (mode_i == huff_pkg::MODE_LOAD);
    assign gnt_query = (mode_i == huff_pkg::MODE_QUERY_HIST) ||
                       (mode_i == huff_pkg::MODE_QUERY_CB);

    assign seq_valid = (gnt_hist && hist_valid) || (gnt_load && load_valid) ||
                       (gnt_query && query_valid);
    assign seq_rec = gnt_load ? load_rec : (gnt_query ? query_rec : hist_rec);

    hist_counter hist_counter_i (
        .clk          (clk),
        .rst          (rst),
        .mode_i       (mode_i),
        .clear_start_i(clear_start_i),
        .clear_done_o (clear_done_o),
        .byte_valid_i (byte_valid_i),
        .byte_i       (byte_i),
        .byte_ready_o (byte_ready_o),
        .rec_valid_o  (hist_valid),
        .rec_o        (hist_rec),
        .rec_ready_i  (seq_ready && gnt_hist),
        .rec_done_i   (seq_done && gnt_hist),
        .rec_rdata_i  (seq_rdata)
    );

    codebook_loader codebook_loader_i (
        .clk        (clk),
        .rst        (rst),
        .mode_i     (mode_i),
        .cb_valid_i (cb_valid_i),
        .cb_sym_i   (cb_sym_i),
        .cb_entry_i (cb_entry_i),
        .cb_ready_o (cb_ready_o),
        .rec_valid_o(load_valid),
        .rec_o      (load_rec),
        .rec_ready_i(seq_ready && gnt_load),
        .rec_done_i (seq_done && gnt_load)
    );

    symbol_lookup symbol_lookup_i (
        .clk        (clk),
        .rst        (rst),
        .mode_i     (mode_i),
        .q_valid_i  (q_valid_i),
        .q_sym_i    (q_sym_i),
        .q_ready_o  (q_ready_o),
        .rsp_valid_o(rsp_valid_o),
        .rsp_o      (rsp_o),
        .rec_valid_o(query_valid),
        .rec_o      (query_rec),
        .rec_ready_i(seq_ready && gnt_query),
        .rec_done_i (seq_done && gnt_query),
        .rec_rdata_i(seq_rdata)
    );

    record_sequencer record_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .rec_valid_i(seq_valid),
        .rec_i      (seq_rec),
        .rec_ready_o(seq_ready),
        .rec_done_o (seq_done),
        .rec_rdata_o(seq_rdata),
        .mem_req_o  (mem_req),
        .mem_go_o   (mem_go),
        .mem_busy_i (mem_busy),
        .mem_rdata_i(mem_rdata)
    );

    word_sram word_sram_i (
        .clk    (clk),
        .rst    (rst),
        .req_i  (mem_req),
        .go_i   (mem_go),
        .busy_o (mem_busy),
        .rdata_o(mem_rdata)
    );

endmodule

// ==== symbol_lookup.sv ====
module symbol_lookup (
    input  logic clk,
    input  logic rst,
    input  huff_pkg::mode_e mode_i,
    input  logic q_valid_i,
    input  logic [7:0] q_sym_i,
    output logic q_ready_o,
    output logic rsp_valid_o,
    output huff_pkg::query_rsp_t rsp_o,
    output logic rec_valid_o,
    output huff_pkg::rec_req_t rec_o,
    input  logic rec_ready_i,
    input  logic rec_done_i,
    input  logic [huff_pkg::REC_W-1:0] rec_rdata_i
);

    logic busy_q;
    logic sent_q;
    logic [7:0] sym_q;
    huff_pkg::rsp_kind_e kind_q;
    logic is_cb;

    assign is_cb = (kind_q == huff_pkg::RSP_CB);
    assign q_ready_o = !busy_q && (mode_i == huff_pkg::MODE_QUERY_HIST ||
                                   mode_i == huff_pkg::MODE_QUERY_CB);
    assign rec_valid_o = busy_q && !sent_q;

    // count is one word, entry is four
    assign rec_o.write = 1'b0;
    assign rec_o.addr = is_cb ? huff_pkg::cb_addr(sym_q) : huff_pkg::hist_addr(sym_q);
    assign rec_o.cnt_m1 = is_cb ? huff_pkg::CB_LAST : 2'd0;
    assign rec_o.data = '0;

    always_ff @(posedge clk) begin
        if (q_valid_i && q_ready_o) begin
            sym_q <= q_sym_i;
            kind_q <= (mode_i == huff_pkg::MODE_QUERY_CB) ? huff_pkg::RSP_CB
                                                          : huff_pkg::RSP_HIST;
        end
        if (rec_done_i) begin
            rsp_o.sym <= sym_q;
            rsp_o.kind <= kind_q;
            rsp_o.data <= rec_rdata_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            sent_q <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= rec_done_i;
            if (q_valid_i && q_ready_o) begin
                busy_q <= 1'b1;
            end else if (rec_done_i) begin
                busy_q <= 1'b0;
            end
            if (rec_valid_o && rec_ready_i) begin
                sent_q <= 1'b1;
            end else if (rec_done_i) begin
                sent_q <= 1'b0;
            end
        end
    end

endmodule

// ==== codebook_loader.sv ====
module codebook_loader (
    input  logic clk,
    input  logic rst,
    input  huff_pkg::mode_e mode_i,
    input  logic cb_valid_i,
    input  logic [7:0] cb_sym_i,
    input  huff_pkg::cb_entry_t cb_entry_i,
    output logic cb_ready_o,
    output logic rec_valid_o,
    output huff_pkg::rec_req_t rec_o,
    input  logic rec_ready_i,
    input  logic rec_done_i
);

    logic busy_q;
    logic sent_q;
    logic [7:0] sym_q;
    huff_pkg::cb_entry_t entry_q;

    assign cb_ready_o = !busy_q && (mode_i == huff_pkg::MODE_LOAD);
    assign rec_valid_o = busy_q && !sent_q;

    // whole entry in one four-word write
    assign rec_o.write = 1'b1;
    assign rec_o.addr = huff_pkg::cb_addr(sym_q);
    assign rec_o.cnt_m1 = huff_pkg::CB_LAST;
    assign rec_o.data = entry_q;

    always_ff @(posedge clk) begin
        if (cb_valid_i && cb_ready_o) begin
            sym_q <= cb_sym_i;
            entry_q <= cb_entry_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            sent_q <= 1'b0;
        end else begin
            if (cb_valid_i && cb_ready_o) begin
                busy_q <= 1'b1;
            end else if (rec_done_i) begin
                busy_q <= 1'b0;
            end
            if (rec_valid_o && rec_ready_i) begin
                sent_q <= 1'b1;
            end else if (rec_done_i) begin
                sent_q <= 1'b0;
            end
        end
    end

endmodule

// ==== hist_counter.sv ====
module hist_counter (
    input  logic clk,
    input  logic rst,
    input  huff_pkg::mode_e mode_i,
    input  logic clear_start_i,
    output logic clear_done_o,
    input  logic byte_valid_i,
    input  logic [7:0] byte_i,
    output logic byte_ready_o,
    output logic rec_valid_o,
    output huff_pkg::rec_req_t rec_o,
    input  logic rec_ready_i,
    input  logic rec_done_i,
    input  logic [huff_pkg::REC_W-1:0] rec_rdata_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_READ,
        S_INC,
        S_WRITE
    } state_e;

    state_e state_q;
    logic [7:0] sym_q;
    logic [huff_pkg::WORD_W-1:0] count_q;
    logic sent_q;

    assign byte_ready_o = (state_q == S_IDLE) && (mode_i == huff_pkg::MODE_COUNT);
    assign rec_valid_o = !sent_q && (state_q == S_CLEAR || state_q == S_READ ||
                                     state_q == S_WRITE);

    // one-word records, write data sits in the first word
    assign rec_o.write = (state_q != S_READ);
    assign rec_o.addr = huff_pkg::hist_addr(sym_q);
    assign rec_o.cnt_m1 = 2'd0;
    assign rec_o.data = {(state_q == S_CLEAR) ? '0 : count_q, 96'd0};

    always_ff @(posedge clk) begin
        if (state_q == S_READ && rec_done_i) begin
            count_q <= rec_rdata_i[huff_pkg::WORD_W-1:0];
        end else if (state_q == S_INC) begin
            // wraps at 2^32
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
            sym_q <= 8'd0;
            sent_q <= 1'b0;
            clear_done_o <= 1'b0;
        end else begin
            if (rec_valid_o && rec_ready_i) begin
                sent_q <= 1'b1;
            end else if (rec_done_i) begin
                sent_q <= 1'b0;
            end
            case (state_q)
                S_IDLE: begin
                    if (mode_i == huff_pkg::MODE_CLEAR && clear_start_i) begin
                        sym_q <= 8'd0;
                        clear_done_o <= 1'b0;
                        state_q <= S_CLEAR;
                    end else if (byte_valid_i && byte_ready_o) begin
                        sym_q <= byte_i;
                        state_q <= S_READ;
                    end
                end
                S_CLEAR: begin
                    if (rec_done_i) begin
                        sym_q <= sym_q + 8'd1;
                        if (int'(sym_q) == huff_pkg::HIST_ENTRIES - 1) begin
                            clear_done_o <= 1'b1;
                            state_q <= S_IDLE;
                        end
                    end
                end
                S_READ: begin
                    if (rec_done_i) begin
                        state_q <= S_INC;
                    end
                end
                S_INC: begin
                    state_q <= S_WRITE;
                end
                default: begin
                    if (rec_done_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== record_sequencer.sv ====
module record_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic rec_valid_i,
    input  huff_pkg::rec_req_t rec_i,
    output logic rec_ready_o,
    output logic rec_done_o,
    output logic [huff_pkg::REC_W-1:0] rec_rdata_o,
    output huff_pkg::mem_req_t mem_req_o,
    output logic mem_go_o,
    input  logic mem_busy_i,
    input  logic [huff_pkg::WORD_W-1:0] mem_rdata_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_GO,
        S_WAIT
    } state_e;

    state_e state_q;
    huff_pkg::rec_req_t rec_q;
    logic [1:0] beat_q;
    logic [huff_pkg::REC_W-1:0] rdata_q;
    logic busy_last_q;
    logic beat_end;
    logic last_beat;
    logic [1:0] issue_idx;
    logic [huff_pkg::ADDR_W-1:0] beat_off;
    logic [huff_pkg::WORD_W-1:0] wr_word;

    // busy falling edge closes the beat in flight
    assign beat_end = (state_q == S_WAIT) && busy_last_q && !mem_busy_i;
    assign last_beat = (beat_q == rec_q.cnt_m1);

    // next beat goes out in the same cycle the previous one ends
    assign issue_idx = (state_q == S_GO) ? beat_q : beat_q + 2'd1;
    assign beat_off = {{(huff_pkg::ADDR_W - 2){1'b0}}, issue_idx};

    always_comb begin
        case (issue_idx)
            2'd0: wr_word = rec_q.data[127:96];
            2'd1: wr_word = rec_q.data[95:64];
            2'd2: wr_word = rec_q.data[63:32];
            default: wr_word = rec_q.data[31:0];
        endcase
    end

    assign mem_req_o.write = rec_q.write;
    assign mem_req_o.addr = rec_q.addr + beat_off;
    assign mem_req_o.wdata = wr_word;
    assign mem_go_o = (state_q == S_GO) || (beat_end && !last_beat);

    assign rec_ready_o = (state_q == S_IDLE);
    assign rec_done_o = beat_end && last_beat;
    // last word lands in 31:0, earlier words shift up
    assign rec_rdata_o = {rdata_q[95:0], mem_rdata_i};

    always_ff @(posedge clk) begin
        if (rec_valid_i && rec_ready_o) begin
            rec_q <= rec_i;
            rdata_q <= '0;
        end else if (beat_end) begin
            rdata_q <= {rdata_q[95:0], mem_rdata_i};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q <= 2'd0;
            busy_last_q <= 1'b0;
        end else begin
            busy_last_q <= mem_busy_i;
            case (state_q)
                S_IDLE: begin
                    if (rec_valid_i) begin
                        beat_q <= 2'd0;
                        state_q <= S_GO;
                    end
                end
                S_GO: begin
                    state_q <= S_WAIT;
                end
                S_WAIT: begin
                    if (beat_end) begin
                        if (last_beat) begin
                            state_q <= S_IDLE;
                        end else begin
                            beat_q <= beat_q + 2'd1;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== word_sram.sv ====
module word_sram (
    input  logic clk,
    input  logic rst,
    input  huff_pkg::mem_req_t req_i,
    input  logic go_i,
    output logic busy_o,
    output logic [huff_pkg::WORD_W-1:0] rdata_o
);

    logic [huff_pkg::WORD_W-1:0] mem_q [huff_pkg::MEM_WORDS];

    // read data stays put across writes
    always_ff @(posedge clk) begin
        if (go_i) begin
            if (req_i.write) begin
                mem_q[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_o <= mem_q[req_i.addr];
            end
        end
    end

    // one busy cycle per access, falls the cycle after
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_o <= 1'b0;
        end else begin
            busy_o <= go_i;
        end
    end

endmodule

// ==== huff_pkg.sv ====
package huff_pkg;

    localparam int MEM_WORDS = 2048;
    localparam int ADDR_W = 11;
    localparam int WORD_W = 32;
    localparam int REC_W = 128;
    localparam int HIST_BASE = 0;
    localparam int HIST_ENTRIES = 256;
    localparam int CB_BASE = 1024;
    localparam int CB_WORDS = 4;
    localparam logic [1:0] CB_LAST = 2'(CB_WORDS - 1);

    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_CLEAR,
        MODE_COUNT,
        MODE_LOAD,
        MODE_QUERY_HIST,
        MODE_QUERY_CB
    } mode_e;

    typedef enum logic {
        RSP_HIST,
        RSP_CB
    } rsp_kind_e;

    // code is msb-aligned, word 0 carries len and the top of code
    typedef struct packed {
        logic [7:0] len;
        logic [119:0] code;
    } cb_entry_t;

    typedef struct packed {
        logic write;
        logic [ADDR_W-1:0] addr;
        logic [1:0] cnt_m1;
        logic [REC_W-1:0] data;
    } rec_req_t;

    typedef struct packed {
        logic write;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [7:0] sym;
        rsp_kind_e kind;
        logic [REC_W-1:0] data;
    } query_rsp_t;

    function automatic logic [ADDR_W-1:0] hist_addr(input logic [7:0] sym);
        return ADDR_W'(HIST_BASE + int'(sym));
    endfunction

    function automatic logic [ADDR_W-1:0] cb_addr(input logic [7:0] sym);
        return ADDR_W'(CB_BASE + CB_WORDS * int'(sym));
    endfunction

endpackage
